/* include/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

////////////////////
// Core constants
////////////////////

// Address of the first instruction fetched after reset
`define CPU_RESET_VECTOR 32'h0000_0000

// Architectural register count, x0 included
`define CPU_NUM_REGS 32

// Unprivileged, secure, data access on every AXI transaction
`define AXI_PROT 3'b000

`endif

/* src/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [31:0] word_t;

  ////////////////////
  // Instruction set
  ////////////////////

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_t;

  // How the decoder picks the ALU operation
  typedef enum logic [1:0] {
    ALU_CLASS_ADD,
    ALU_CLASS_SUB,
    ALU_CLASS_FUNCT
  } alu_class_t;

  ////////////////////
  // Control
  ////////////////////

  typedef enum logic [3:0] {
    S_FETCH,
    S_DECODE,
    S_MEM_ADR,
    S_MEM_READ,
    S_MEM_WB,
    S_MEM_WRITE,
    S_EXEC_R,
    S_EXEC_I,
    S_ALU_WB,
    S_BRANCH,
    S_JAL
  } fsm_state_t;

  typedef enum logic {ADR_SRC_PC, ADR_SRC_RESULT} adr_src_t;
  typedef enum logic {PC_SRC_RESULT, PC_SRC_OLD_PC_IMM} pc_src_t;
  typedef enum logic [1:0] {ALU_SRC_A_PC, ALU_SRC_A_OLD_PC, ALU_SRC_A_RD1} alu_src_a_t;
  typedef enum logic [1:0] {ALU_SRC_B_RD2, ALU_SRC_B_IMM, ALU_SRC_B_4} alu_src_b_t;

  typedef enum logic [1:0] {
    RESULT_SRC_ALU_OUT,
    RESULT_SRC_DATA,
    RESULT_SRC_ALU_RESULT
  } result_src_t;

  // Bus bridge states
  typedef enum logic [2:0] {AX_IDLE, AX_WRITE, AX_WRESP, AX_RADDR, AX_RDATA} axi_state_t;

endpackage

/* src/mem_if.sv */
`timescale 1ns/1ns

// One word request at a time between the core and the bus bridge
interface mem_if;

  logic           req;
  logic           write;
  cpu_pkg::word_t addr;
  cpu_pkg::word_t wdata;
  cpu_pkg::word_t rdata;
  logic           done;

  modport core (
    output req, write, addr, wdata,
    input  rdata, done
  );

  modport bus (
    input  req, write, addr, wdata,
    output rdata, done
  );

endinterface

/* src/alu.sv */
`timescale 1ns/1ns

module alu (
  input  cpu_pkg::word_t    a,
  input  cpu_pkg::word_t    b,
  input  cpu_pkg::alu_op_t  op,
  output cpu_pkg::word_t    y,
  output logic              zero
);

  logic lt;

  // Signed compare for slt and slti
  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      cpu_pkg::ALU_ADD: y = a + b;
      cpu_pkg::ALU_SUB: y = a - b;
      cpu_pkg::ALU_AND: y = a & b;
      cpu_pkg::ALU_OR:  y = a | b;
      cpu_pkg::ALU_SLT: y = {31'b0, lt};
      default:          y = a + b;
    endcase
  end

  assign zero = (y == '0);

endmodule

/* src/fetch.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module fetch (
  input  logic              clk,
  input  logic              reset,
  input  logic              pc_update,
  input  logic              ir_write,
  input  cpu_pkg::pc_src_t  pc_src,
  input  cpu_pkg::word_t    imm_ext,
  input  cpu_pkg::word_t    result,
  input  cpu_pkg::word_t    rdata,
  output cpu_pkg::word_t    pc,
  output cpu_pkg::word_t    pc_old,
  output cpu_pkg::word_t    instr
);

  cpu_pkg::word_t pc_next;

  always_comb begin
    case (pc_src)
      cpu_pkg::PC_SRC_RESULT: pc_next = result;
      default:                pc_next = pc_old + imm_ext;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CPU_RESET_VECTOR;
    end else if (pc_update) begin
      pc <= pc_next;
    end
  end

  // The old PC is the address of the instruction now in the IR
  always_ff @(posedge clk) begin
    if (ir_write) begin
      instr  <= rdata;
      pc_old <= pc;
    end
  end

endmodule

/* src/instr_decode.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module instr_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  cpu_pkg::word_t       instr,
  input  logic                 reg_write,
  input  cpu_pkg::word_t       result,
  input  cpu_pkg::alu_class_t  alu_class,
  output cpu_pkg::opcode_t     opcode,
  output cpu_pkg::word_t       rd1,
  output cpu_pkg::word_t       rd2,
  output cpu_pkg::word_t       imm_ext,
  output cpu_pkg::alu_op_t     alu_op
);

  cpu_pkg::word_t regs [0:`CPU_NUM_REGS-1];
  logic [4:0]     rs1;
  logic [4:0]     rs2;
  logic [4:0]     rd;
  logic [2:0]     funct3;

  assign opcode = cpu_pkg::opcode_t'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  ////////////////////
  // Register file
  ////////////////////

  // x0 is never written so it reads as zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && rd != 5'd0) begin
      regs[rd] <= result;
    end
  end

  assign rd1 = regs[rs1];
  assign rd2 = regs[rs2];

  always_comb begin
    case (opcode)
      cpu_pkg::OP_STORE:  imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      cpu_pkg::OP_BRANCH: imm_ext = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
      cpu_pkg::OP_JAL:    imm_ext = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
      default:            imm_ext = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  // Only R-type uses bit 30 to pick subtract
  always_comb begin
    alu_op = cpu_pkg::ALU_ADD;
    case (alu_class)
      cpu_pkg::ALU_CLASS_SUB: alu_op = cpu_pkg::ALU_SUB;
      cpu_pkg::ALU_CLASS_FUNCT: begin
        case (funct3)
          3'b000: begin
            if (opcode == cpu_pkg::OP_REG && instr[30]) begin
              alu_op = cpu_pkg::ALU_SUB;
            end
          end
          3'b010:  alu_op = cpu_pkg::ALU_SLT;
          3'b110:  alu_op = cpu_pkg::ALU_OR;
          3'b111:  alu_op = cpu_pkg::ALU_AND;
          default: alu_op = cpu_pkg::ALU_ADD;
        endcase
      end
      default: alu_op = cpu_pkg::ALU_ADD;
    endcase
  end

endmodule

/* src/control_fsm.sv */
`timescale 1ns/1ns

module control_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  cpu_pkg::opcode_t         opcode,
  input  logic                     zero,
  mem_if.core                      mem,
  output logic                     ir_write,
  output logic                     pc_update,
  output logic                     reg_write,
  output cpu_pkg::pc_src_t         pc_src,
  output cpu_pkg::adr_src_t        adr_src,
  output cpu_pkg::alu_src_a_t      alu_src_a,
  output cpu_pkg::alu_src_b_t      alu_src_b,
  output cpu_pkg::result_src_t     result_src,
  output cpu_pkg::alu_class_t      alu_class
);

  cpu_pkg::fsm_state_t state;
  cpu_pkg::fsm_state_t state_next;
  logic                first_cycle;
  logic                bus_req;
  logic                bus_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= cpu_pkg::S_FETCH;
      first_cycle <= 1'b1;
    end else begin
      state       <= state_next;
      first_cycle <= 1'b0;
    end
  end

  // The bus stays quiet for one cycle after reset
  assign mem.req   = bus_req && !first_cycle;
  assign mem.write = bus_write;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_next = state;
    case (state)
      cpu_pkg::S_FETCH: if (mem.done) state_next = cpu_pkg::S_DECODE;
      cpu_pkg::S_DECODE: begin
        case (opcode)
          cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE: state_next = cpu_pkg::S_MEM_ADR;
          cpu_pkg::OP_REG:    state_next = cpu_pkg::S_EXEC_R;
          cpu_pkg::OP_IMM:    state_next = cpu_pkg::S_EXEC_I;
          cpu_pkg::OP_BRANCH: state_next = cpu_pkg::S_BRANCH;
          cpu_pkg::OP_JAL:    state_next = cpu_pkg::S_JAL;
          default:            state_next = cpu_pkg::S_FETCH;
        endcase
      end
      cpu_pkg::S_MEM_ADR: begin
        if (opcode == cpu_pkg::OP_LOAD) begin
          state_next = cpu_pkg::S_MEM_READ;
        end else begin
          state_next = cpu_pkg::S_MEM_WRITE;
        end
      end
      cpu_pkg::S_MEM_READ:  if (mem.done) state_next = cpu_pkg::S_MEM_WB;
      cpu_pkg::S_MEM_WRITE: if (mem.done) state_next = cpu_pkg::S_FETCH;
      cpu_pkg::S_EXEC_R, cpu_pkg::S_EXEC_I: state_next = cpu_pkg::S_ALU_WB;
      default: state_next = cpu_pkg::S_FETCH;
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  always_comb begin
    ir_write   = 1'b0;
    pc_update  = 1'b0;
    reg_write  = 1'b0;
    bus_req    = 1'b0;
    bus_write  = 1'b0;
    pc_src     = cpu_pkg::PC_SRC_RESULT;
    adr_src    = cpu_pkg::ADR_SRC_PC;
    alu_src_a  = cpu_pkg::ALU_SRC_A_RD1;
    alu_src_b  = cpu_pkg::ALU_SRC_B_RD2;
    result_src = cpu_pkg::RESULT_SRC_ALU_OUT;
    alu_class  = cpu_pkg::ALU_CLASS_ADD;
    case (state)
      cpu_pkg::S_FETCH: begin
        // PC+4 goes straight to the PC when the instruction arrives
        bus_req    = 1'b1;
        alu_src_a  = cpu_pkg::ALU_SRC_A_PC;
        alu_src_b  = cpu_pkg::ALU_SRC_B_4;
        result_src = cpu_pkg::RESULT_SRC_ALU_RESULT;
        ir_write   = mem.done;
        pc_update  = mem.done;
      end
      cpu_pkg::S_DECODE: begin
        alu_src_a = cpu_pkg::ALU_SRC_A_OLD_PC;
        alu_src_b = cpu_pkg::ALU_SRC_B_IMM;
      end
      cpu_pkg::S_MEM_ADR, cpu_pkg::S_MEM_READ, cpu_pkg::S_MEM_WRITE: begin
        // Address stays in alu_out for the whole bus wait
        alu_src_b = cpu_pkg::ALU_SRC_B_IMM;
        adr_src   = cpu_pkg::ADR_SRC_RESULT;
        bus_req   = (state != cpu_pkg::S_MEM_ADR);
        bus_write = (state == cpu_pkg::S_MEM_WRITE);
      end
      cpu_pkg::S_MEM_WB: begin
        result_src = cpu_pkg::RESULT_SRC_DATA;
        reg_write  = 1'b1;
      end
      cpu_pkg::S_EXEC_R: alu_class = cpu_pkg::ALU_CLASS_FUNCT;
      cpu_pkg::S_EXEC_I: begin
        alu_src_b = cpu_pkg::ALU_SRC_B_IMM;
        alu_class = cpu_pkg::ALU_CLASS_FUNCT;
      end
      cpu_pkg::S_ALU_WB: reg_write = 1'b1;
      cpu_pkg::S_BRANCH: begin
        alu_class = cpu_pkg::ALU_CLASS_SUB;
        pc_update = zero;
      end
      cpu_pkg::S_JAL: begin
        // Link value is old PC + 4, target is old PC + imm
        alu_src_a  = cpu_pkg::ALU_SRC_A_OLD_PC;
        alu_src_b  = cpu_pkg::ALU_SRC_B_4;
        result_src = cpu_pkg::RESULT_SRC_ALU_RESULT;
        reg_write  = 1'b1;
        pc_update  = 1'b1;
        pc_src     = cpu_pkg::PC_SRC_OLD_PC_IMM;
      end
      default: ;
    endcase
  end

endmodule

/* src/axil_master.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module axil_master (
  input  logic        clk,
  input  logic        reset,
  mem_if.bus          mem,
  output logic [31:0] awaddr,
  output logic [2:0]  awprot,
  output logic        awvalid,
  input  logic        awready,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb,
  output logic        wvalid,
  input  logic        wready,
  input  logic [1:0]  bresp,
  input  logic        bvalid,
  output logic        bready,
  output logic [31:0] araddr,
  output logic [2:0]  arprot,
  output logic        arvalid,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rvalid,
  output logic        rready
);

  cpu_pkg::axi_state_t state;
  logic                done_q;
  cpu_pkg::word_t      rdata_q;

  // The core holds addr and wdata stable until done
  assign awaddr = mem.addr;
  assign araddr = mem.addr;
  assign wdata  = mem.wdata;
  assign awprot = `AXI_PROT;
  assign arprot = `AXI_PROT;
  assign wstrb  = 4'hf;

  assign mem.done  = done_q;
  assign mem.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= cpu_pkg::AX_IDLE;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        cpu_pkg::AX_IDLE: begin
          // req is still high in the done cycle, so skip it
          if (mem.req && !done_q) begin
            if (mem.write) begin
              awvalid <= 1'b1;
              wvalid  <= 1'b1;
              state   <= cpu_pkg::AX_WRITE;
            end else begin
              arvalid <= 1'b1;
              state   <= cpu_pkg::AX_RADDR;
            end
          end
        end
        cpu_pkg::AX_WRITE: begin
          if (awready) awvalid <= 1'b0;
          if (wready) wvalid <= 1'b0;
          if ((awready || !awvalid) && (wready || !wvalid)) begin
            bready <= 1'b1;
            state  <= cpu_pkg::AX_WRESP;
          end
        end
        cpu_pkg::AX_WRESP: begin
          if (bvalid) begin
            bready <= 1'b0;
            done_q <= 1'b1;
            state  <= cpu_pkg::AX_IDLE;
          end
        end
        cpu_pkg::AX_RADDR: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= cpu_pkg::AX_RDATA;
          end
        end
        cpu_pkg::AX_RDATA: begin
          if (rvalid) begin
            rready <= 1'b0;
            done_q <= 1'b1;
            state  <= cpu_pkg::AX_IDLE;
          end
        end
        default: state <= cpu_pkg::AX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cpu_pkg::AX_RDATA && rvalid) begin
      rdata_q <= rdata;
    end
  end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] awaddr,
  output logic [2:0]  awprot,
  output logic        awvalid,
  input  logic        awready,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb,
  output logic        wvalid,
  input  logic        wready,
  input  logic [1:0]  bresp,
  input  logic        bvalid,
  output logic        bready,
  output logic [31:0] araddr,
  output logic [2:0]  arprot,
  output logic        arvalid,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic [1:0]  rresp,
  input  logic        rvalid,
  output logic        rready
);

  logic                  ir_write;
  logic                  pc_update;
  logic                  reg_write;
  logic                  zero;
  cpu_pkg::pc_src_t      pc_src;
  cpu_pkg::adr_src_t     adr_src;
  cpu_pkg::alu_src_a_t   alu_src_a;
  cpu_pkg::alu_src_b_t   alu_src_b;
  cpu_pkg::result_src_t  result_src;
  cpu_pkg::alu_class_t   alu_class;
  cpu_pkg::alu_op_t      alu_op;
  cpu_pkg::opcode_t      opcode;

  cpu_pkg::word_t pc;
  cpu_pkg::word_t pc_old;
  cpu_pkg::word_t instr;
  cpu_pkg::word_t imm_ext;
  cpu_pkg::word_t rd1;
  cpu_pkg::word_t rd2;
  cpu_pkg::word_t src_a;
  cpu_pkg::word_t src_b;
  cpu_pkg::word_t alu_result;
  cpu_pkg::word_t alu_out;
  cpu_pkg::word_t result;
  cpu_pkg::word_t mem_addr;

  mem_if mem ();

  ////////////////////
  // Control
  ////////////////////

  control_fsm control_fsm_inst (
    .clk(clk), .reset(reset), .opcode(opcode), .zero(zero), .mem(mem),
    .ir_write(ir_write), .pc_update(pc_update), .reg_write(reg_write),
    .pc_src(pc_src), .adr_src(adr_src), .alu_src_a(alu_src_a),
    .alu_src_b(alu_src_b), .result_src(result_src), .alu_class(alu_class)
  );

  ////////////////////
  // Datapath
  ////////////////////

  fetch fetch_inst (
    .clk(clk), .reset(reset), .pc_update(pc_update), .ir_write(ir_write),
    .pc_src(pc_src), .imm_ext(imm_ext), .result(result), .rdata(mem.rdata),
    .pc(pc), .pc_old(pc_old), .instr(instr)
  );

  instr_decode instr_decode_inst (
    .clk(clk), .reset(reset), .instr(instr), .reg_write(reg_write),
    .result(result), .alu_class(alu_class), .opcode(opcode),
    .rd1(rd1), .rd2(rd2), .imm_ext(imm_ext), .alu_op(alu_op)
  );

  alu alu_inst (.a(src_a), .b(src_b), .op(alu_op), .y(alu_result), .zero(zero));

  always_ff @(posedge clk) begin
    alu_out <= alu_result;
  end

  always_comb begin
    case (adr_src)
      cpu_pkg::ADR_SRC_PC: mem_addr = pc;
      default:             mem_addr = result;
    endcase
  end

  always_comb begin
    case (alu_src_a)
      cpu_pkg::ALU_SRC_A_PC:     src_a = pc;
      cpu_pkg::ALU_SRC_A_OLD_PC: src_a = pc_old;
      default:                   src_a = rd1;
    endcase
  end

  always_comb begin
    case (alu_src_b)
      cpu_pkg::ALU_SRC_B_IMM: src_b = imm_ext;
      cpu_pkg::ALU_SRC_B_4:   src_b = 32'd4;
      default:                src_b = rd2;
    endcase
  end

  always_comb begin
    case (result_src)
      cpu_pkg::RESULT_SRC_DATA:       result = mem.rdata;
      cpu_pkg::RESULT_SRC_ALU_RESULT: result = alu_result;
      default:                        result = alu_out;
    endcase
  end

  assign mem.addr  = mem_addr;
  assign mem.wdata = rd2;

  ////////////////////
  // Bus bridge
  ////////////////////

  axil_master axil_master_inst (
    .clk(clk), .reset(reset), .mem(mem),
    .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

endmodule

/* tests/cpu_tb.sv */
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_tb;

  localparam int NUM_PROGS    = 4;
  localparam int RAND_INSTRS  = 40;
  localparam int MAX_INSTRS   = 50;
  localparam int RESET_CYCLES = 16;
  localparam int MEM_WORDS    = 1024;
  // Five cycles per instruction at most, stretched up to eight times by bus delays
  localparam int CYCLE_LIMIT  = NUM_PROGS * (MAX_INSTRS * 5 * 8 + RESET_CYCLES + 2);

  localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
  localparam logic [6:0]  OPC_STORE  = 7'b0100011;
  localparam logic [6:0]  OPC_IMM    = 7'b0010011;
  localparam logic [6:0]  OPC_REG    = 7'b0110011;
  localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
  localparam logic [6:0]  OPC_JAL    = 7'b1101111;
  localparam logic [31:0] HALT_INSTR = 32'h0000_006f;
  localparam int          DUMP_WORD  = 32'h600 >> 2;

  logic        clk;
  logic        reset;
  logic [31:0] awaddr;
  logic [2:0]  awprot;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic [2:0]  arprot;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [31:0] bus_mem   [0:MEM_WORDS-1];
  logic [31:0] model_mem [0:MEM_WORDS-1];
  logic [31:0] xreg      [0:31];
  logic [31:0] exp_reads[$];
  logic [31:0] exp_wr_addr[$];
  logic [31:0] exp_wr_data[$];
  logic [31:0] lfsr_state;
  logic [31:0] halt_addr;
  logic [31:0] last_read;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [31:0] rd_addr;
  logic        aw_got;
  logic        w_got;
  logic        ar_got;
  logic        b_fire;
  logic        r_fire;
  logic        prog_done;
  int          aw_dly;
  int          w_dly;
  int          b_dly;
  int          ar_dly;
  int          r_dly;
  int          cycle_count;

  cpu_top cpu_top_inst (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(logic [31:0] actual, logic [31:0] expected, string msg);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch at %0d ns: %s, got %h, expected %h",
                          $time, msg, actual, expected));
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [31:0] v;
    v = rand_bits(3);
    return (v == 0) ? 5'd1 : v[4:0];
  endfunction

  function automatic logic [31:0] fill_word(int index);
    logic [31:0] a;
    a = 32'(index) << 2;
    return a ^ {a[15:0], a[31:16]} ^ 32'h6b1d_3c5a;
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  ////////////////////
  // Program and model
  ////////////////////

  task automatic build_program();
    logic [31:0] ins;
    logic [31:0] imm;
    logic [31:0] fwd;
    logic [11:0] dofs;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          kind;
    for (int i = 0; i < MEM_WORDS; i++) begin
      bus_mem[i] = fill_word(i);
    end
    for (int i = 0; i < RAND_INSTRS; i++) begin
      kind = int'(rand_bits(4) % 13);
      rd   = pick_reg();
      rs1  = pick_reg();
      rs2  = pick_reg();
      imm  = rand_bits(12);
      fwd  = 1 + rand_bits(2);
      dofs = 12'(32'h400 + (rand_bits(6) << 2));
      // Targets never pass the first register dump store
      if (i + fwd > RAND_INSTRS) begin
        fwd = 32'(RAND_INSTRS - i);
      end
      case (kind)
        0:       ins = enc_i(dofs, 5'd0, 3'b010, rd, OPC_LOAD);
        1:       ins = enc_s(dofs, rs2, 5'd0);
        2:       ins = enc_i(imm[11:0], rs1, 3'b000, rd, OPC_IMM);
        3:       ins = enc_i(imm[11:0], rs1, 3'b111, rd, OPC_IMM);
        4:       ins = enc_i(imm[11:0], rs1, 3'b110, rd, OPC_IMM);
        5:       ins = enc_i(imm[11:0], rs1, 3'b010, rd, OPC_IMM);
        6:       ins = enc_r(7'h00, rs2, rs1, 3'b000, rd);
        7:       ins = enc_r(7'h20, rs2, rs1, 3'b000, rd);
        8:       ins = enc_r(7'h00, rs2, rs1, 3'b111, rd);
        9:       ins = enc_r(7'h00, rs2, rs1, 3'b110, rd);
        10:      ins = enc_r(7'h00, rs2, rs1, 3'b010, rd);
        11:      ins = enc_b(13'(fwd << 2), rs2, rs1);
        default: ins = enc_j(21'(fwd << 2), rd);
      endcase
      bus_mem[i] = ins;
    end
    // Dump x1 to x7 so every register value reaches the bus
    for (int r = 1; r <= 7; r++) begin
      bus_mem[RAND_INSTRS + r - 1] = enc_s(12'(32'h600 + 4 * (r - 1)), 5'(r), 5'd0);
    end
    bus_mem[RAND_INSTRS + 7] = HALT_INSTR;
    halt_addr = 32'((RAND_INSTRS + 7) * 4);
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = bus_mem[i];
    end
  endtask

  function automatic logic [31:0] isa_alu(logic [2:0] f3, logic sub, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return a + b;
    endcase
  endfunction

  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        wb;
    logic        halted;
    int          steps;
    for (int r = 0; r < 32; r++) begin
      xreg[r] = '0;
    end
    exp_reads.delete();
    exp_wr_addr.delete();
    exp_wr_data.delete();
    pc     = `CPU_RESET_VECTOR;
    halted = 1'b0;
    steps  = 0;
    while (!halted) begin
      if (steps == MAX_INSTRS) begin
        abort_run("Reference model did not reach the halt instruction");
      end
      steps++;
      exp_reads.push_back(pc);
      ins = model_mem[pc[11:2]];
      a   = xreg[ins[19:15]];
      b   = xreg[ins[24:20]];
      nxt = pc + 4;
      wb  = 1'b0;
      res = '0;
      case (ins[6:0])
        OPC_LOAD: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          exp_reads.push_back(addr);
          res = model_mem[addr[11:2]];
          wb  = 1'b1;
        end
        OPC_STORE: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          exp_wr_addr.push_back(addr);
          exp_wr_data.push_back(b);
          model_mem[addr[11:2]] = b;
        end
        OPC_IMM: begin
          res = isa_alu(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
          wb  = 1'b1;
        end
        OPC_REG: begin
          res = isa_alu(ins[14:12], ins[30], a, b);
          wb  = 1'b1;
        end
        OPC_BRANCH: begin
          if (a == b) begin
            nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        OPC_JAL: begin
          res = pc + 4;
          wb  = 1'b1;
          nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: ;
      endcase
      if (wb && ins[11:7] != 5'd0) begin
        xreg[ins[11:7]] = res;
      end
      // A jump to itself is the halt, which the core fetches once more
      if (nxt == pc) begin
        exp_reads.push_back(pc);
        halted = 1'b1;
      end
      pc = nxt;
    end
  endtask

  ////////////////////
  // AXI4-Lite responder
  ////////////////////

  task automatic new_write_delays();
    aw_dly = int'(rand_bits(2));
    w_dly  = int'(rand_bits(2));
    b_dly  = int'(rand_bits(2));
  endtask

  task automatic new_read_delays();
    ar_dly = int'(rand_bits(2));
    r_dly  = int'(rand_bits(2));
  endtask

  task automatic clear_responder();
    awready   = 1'b0;
    wready    = 1'b0;
    arready   = 1'b0;
    bvalid    = 1'b0;
    rvalid    = 1'b0;
    rdata     = '0;
    aw_got    = 1'b0;
    w_got     = 1'b0;
    ar_got    = 1'b0;
    b_fire    = 1'b0;
    r_fire    = 1'b0;
    prog_done = 1'b0;
    last_read = '1;
    new_write_delays();
    new_read_delays();
  endtask

  task automatic take_read(logic [31:0] addr);
    if (exp_reads.size() == 0) begin
      abort_run($sformatf("Read of address %h after the program should have halted", addr));
    end
    check_value(addr, exp_reads.pop_front(), "read address");
    if (addr == halt_addr && last_read == halt_addr) begin
      prog_done = 1'b1;
    end
    last_read = addr;
  endtask

  task automatic take_write(logic [31:0] addr, logic [31:0] data);
    if (exp_wr_addr.size() == 0) begin
      abort_run($sformatf("Write to address %h that the program does not make", addr));
    end
    check_value(addr, exp_wr_addr.pop_front(), "write address");
    check_value(data, exp_wr_data.pop_front(), "write data");
    bus_mem[addr[11:2]] = data;
  endtask

  task automatic check_single_outstanding();
    if (arvalid && (ar_got || aw_got || w_got)) begin
      abort_run("Read request raised before the previous response");
    end
    if ((awvalid || wvalid) && ar_got) begin
      abort_run("Write request raised before the previous read response");
    end
    if ((awvalid && aw_got) || (wvalid && w_got)) begin
      abort_run("Second write request raised before the write response");
    end
  endtask

  // Runs at each falling edge; a ready is pulsed only while its valid is seen high
  task automatic bus_step();
    if (b_fire) begin
      bvalid = 1'b0;
      b_fire = 1'b0;
      aw_got = 1'b0;
      w_got  = 1'b0;
      new_write_delays();
    end
    if (r_fire) begin
      rvalid = 1'b0;
      r_fire = 1'b0;
      ar_got = 1'b0;
      new_read_delays();
    end
    awready = 1'b0;
    wready  = 1'b0;
    arready = 1'b0;
    check_single_outstanding();

    if (awvalid && !aw_got) begin
      if (aw_dly > 0) begin
        aw_dly--;
      end else begin
        awready = 1'b1;
        aw_got  = 1'b1;
        wr_addr = awaddr;
        check_value(32'(awprot), 32'd0, "write protection");
      end
    end
    if (wvalid && !w_got) begin
      if (w_dly > 0) begin
        w_dly--;
      end else begin
        wready  = 1'b1;
        w_got   = 1'b1;
        wr_data = wdata;
        check_value(32'(wstrb), 32'hf, "write strobe");
      end
    end
    if (arvalid && !ar_got) begin
      if (ar_dly > 0) begin
        ar_dly--;
      end else begin
        arready = 1'b1;
        ar_got  = 1'b1;
        rd_addr = araddr;
        check_value(32'(arprot), 32'd0, "read protection");
        take_read(araddr);
      end
    end

    // Responses start only after the request handshakes are done
    if (aw_got && w_got && !awready && !wready && !bvalid) begin
      if (b_dly > 0) begin
        b_dly--;
      end else begin
        bvalid = 1'b1;
        take_write(wr_addr, wr_data);
      end
    end
    if (ar_got && !arready && !rvalid) begin
      if (r_dly > 0) begin
        r_dly--;
      end else begin
        rvalid = 1'b1;
        rdata  = bus_mem[rd_addr[11:2]];
      end
    end
    b_fire = bvalid && bready;
    r_fire = rvalid && rready;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  task automatic check_idle(string where);
    check_value(32'(awvalid), 32'd0, {"awvalid ", where});
    check_value(32'(wvalid), 32'd0, {"wvalid ", where});
    check_value(32'(arvalid), 32'd0, {"arvalid ", where});
    check_value(32'(bready), 32'd0, {"bready ", where});
    check_value(32'(rready), 32'd0, {"rready ", where});
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    clear_responder();
    repeat (RESET_CYCLES) @(negedge clk);
    check_idle("during reset");
    reset = 1'b0;
    @(negedge clk);
    check_idle("in the first cycle after reset");
  endtask

  task automatic run_program();
    while (!prog_done) begin
      @(negedge clk);
      bus_step();
    end
    check_value(32'(exp_reads.size()), 32'd0, "reads left at halt");
    check_value(32'(exp_wr_addr.size()), 32'd0, "stores left at halt");
    for (int r = 1; r <= 7; r++) begin
      check_value(bus_mem[DUMP_WORD + r - 1], xreg[r], $sformatf("final value of x%0d", r));
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(negedge clk);
      cycle_count++;
    end
    abort_run("Timeout: processor did not reach halt");
  end

  initial begin
    reset      = 1'b1;
    awready    = 1'b0;
    wready     = 1'b0;
    arready    = 1'b0;
    bresp      = 2'b00;
    bvalid     = 1'b0;
    rdata      = '0;
    rresp      = 2'b00;
    rvalid     = 1'b0;
    lfsr_state = 32'hb9a6;
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program();
      run_model();
      apply_reset();
      run_program();
    end
    $display("Test passed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
src/cpu_pkg.sv
src/mem_if.sv
src/alu.sv
src/fetch.sv
src/instr_decode.sv
src/control_fsm.sv
src/axil_master.sv
src/cpu_top.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpu_tb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cpu_tb -Mdir obj_dir -f vlog.f

./obj_dir/Vcpu_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1
